//--- filelist.f
hw/sdram_tester_pkg.sv
hw/button_step.sv
hw/mem_access.sv
hw/test_sequencer.sv
hw/port_display.sv
hw/sdram_tester_top.sv
sim/sdram_ctrl_model.sv
sim/tb_sdram_tester.sv

//--- hw/button_step.sv
`timescale 1ns/1ps

module button_step (
    input  logic sdram_clk,
    input  logic rst_n,
    input  logic button_b1,    // Low while pressed
    output logic step
);

    logic btn_meta;     // First synchronizer stage
    logic btn_sync;     // Safe to use
    logic lock;         // Set once a press has been taken

    always_ff @(posedge sdram_clk) begin
        if (!rst_n) begin
            btn_meta <= 1'b1;       // Released
            btn_sync <= 1'b1;
            lock     <= 1'b0;
            step     <= 1'b0;
        end else begin
            btn_meta <= button_b1;
            btn_sync <= btn_meta;
            step     <= !btn_sync && !lock;     // Only the first cycle of a press
            if (btn_sync) begin
                lock <= 1'b0;       // Released so arm again
            end else begin
                lock <= 1'b1;       // Held down
            end
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // A long press must still give a single step
    a_step_single: assert property (@(posedge sdram_clk) disable iff (!rst_n)
        step |=> !step);

endmodule

//--- hw/mem_access.sv
`timescale 1ns/1ps

module mem_access (
    input  logic                        sdram_clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        op_write,
    input  sdram_tester_pkg::mem_addr_t op_addr,
    input  sdram_tester_pkg::mem_word_t op_wdata,
    input  logic                        mem_ready,
    input  sdram_tester_pkg::mem_word_t mem_rdata,
    output sdram_tester_pkg::mem_req_t  mem_req,
    output logic                        done,
    output logic                        rdata_valid,
    output sdram_tester_pkg::mem_word_t rdata
);
    import sdram_tester_pkg::*;

    typedef enum logic [1:0] {
        MA_IDLE,
        MA_WAIT_LOW,    // Controller must drop ready first
        MA_STROBE,
        MA_WAIT_HIGH    // Ready back means the access is over
    } ma_state_t;

    ma_state_t             state;
    logic                  is_write;    // Latched op type
    logic [HOLD_CNT_W-1:0] hold_cnt;    // Strobe cycles so far
    logic                  strobe_on;

    assign strobe_on = mem_req.rstrb | (|mem_req.wmask);

    always_ff @(posedge sdram_clk) begin
        done        <= 1'b0;    // Single cycle pulses
        rdata_valid <= 1'b0;
        if (!rst_n) begin
            state         <= MA_IDLE;
            is_write      <= 1'b0;
            hold_cnt      <= '0;
            mem_req.rstrb <= 1'b0;
            mem_req.wmask <= '0;
        end else begin
            case (state)
                MA_IDLE: begin
                    if (start) begin
                        mem_req.addr  <= op_addr;   // Setup with strobes still low
                        mem_req.wdata <= op_wdata;
                        is_write      <= op_write;
                        state         <= MA_WAIT_LOW;
                    end
                end
                MA_WAIT_LOW: begin
                    if (!mem_ready) begin
                        mem_req.rstrb <= !is_write;
                        mem_req.wmask <= is_write ? 4'b1111 : 4'b0000;  // Mask is the strobe
                        hold_cnt      <= '0;
                        state         <= MA_STROBE;
                    end
                end
                MA_STROBE: begin
                    if (hold_cnt == HOLD_CNT_W'(STROBE_HOLD_CYCLES - 1)) begin
                        mem_req.rstrb <= 1'b0;      // Release
                        mem_req.wmask <= '0;
                        state         <= MA_WAIT_HIGH;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                MA_WAIT_HIGH: begin
                    if (mem_ready) begin
                        if (!is_write) begin
                            rdata       <= mem_rdata;   // Word valid with ready
                            rdata_valid <= 1'b1;
                        end
                        done  <= 1'b1;
                        state <= MA_IDLE;
                    end
                end
                default: state <= MA_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_strobe_excl: assert property (@(posedge sdram_clk) disable iff (!rst_n)
        !(mem_req.rstrb && (|mem_req.wmask)));

    // Controller may sample the address on any strobe cycle
    a_addr_stable: assert property (@(posedge sdram_clk) disable iff (!rst_n)
        strobe_on && $past(strobe_on) |-> $stable(mem_req.addr));

endmodule

//--- hw/port_display.sv
`timescale 1ns/1ps

module port_display (
    input  logic                         sdram_clk,
    input  logic                         rst_n,
    input  logic                         rdata_valid,
    input  sdram_tester_pkg::mem_word_t  rdata,
    input  sdram_tester_pkg::disp_sel_t  disp_sel,
    input  logic [1:0]                   byte_idx,
    input  sdram_tester_pkg::op_idx_t    op_idx,
    output sdram_tester_pkg::port_byte_t port_a
);
    import sdram_tester_pkg::*;

    mem_word_t  shown_word;     // Last word read back
    port_byte_t port_nxt;

    always_ff @(posedge sdram_clk) begin
        if (rdata_valid) begin
            shown_word <= rdata;
        end
    end

    // Pick what goes on the LEDs
    always_comb begin
        case (disp_sel)
            DISP_BYTE: port_nxt = shown_word[byte_idx*8 +: 8];     // Byte lane select
            DISP_MARK: port_nxt = port_byte_t'(op_idx) + 8'd1;    // Marker is op number plus one
            DISP_IDLE: port_nxt = IDLE_PATTERN;
            default:   port_nxt = '0;
        endcase
    end

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge sdram_clk) begin
        if (!rst_n) begin
            port_a <= '0;       // LEDs off
        end else begin
            port_a <= port_nxt;
        end
    end

endmodule

//--- hw/sdram_tester_pkg.sv
package sdram_tester_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    typedef logic [24:0] mem_addr_t;    // Controller byte address
    typedef logic [31:0] mem_word_t;    // One controller data word
    typedef logic [3:0]  wmask_t;       // One bit per byte lane
    typedef logic [7:0]  port_byte_t;   // Port A LEDs
    typedef logic [2:0]  op_idx_t;      // Position in the script

    // Request as the controller samples it
    typedef struct packed {
        mem_addr_t addr;
        mem_word_t wdata;
        wmask_t    wmask;   // Any bit set starts a write
        logic      rstrb;   // Starts a read
    } mem_req_t;

    typedef enum logic [1:0] {
        DISP_CLEAR,
        DISP_BYTE,
        DISP_MARK,
        DISP_IDLE
    } disp_sel_t;

    typedef enum logic [2:0] {
        SEQ_RESET,          // Controller reset, first cycle
        SEQ_RESETTING,      // Controller reset, second cycle
        SEQ_INIT_WAIT,
        SEQ_ACCESS,
        SEQ_SHOW_BYTE,
        SEQ_SHOW_MARK,
        SEQ_IDLE
    } seq_state_t;

    // ----------------------------------------
    // Test script
    // ----------------------------------------
    localparam int TEST_OP_COUNT = 6;
    localparam mem_addr_t TEST_OP_ADDR [TEST_OP_COUNT] = '{
        25'h00_0000, 25'h00_0004, 25'h00_0008,
        25'h00_0008, 25'h00_000c, 25'h00_000c
    };
    localparam logic [TEST_OP_COUNT-1:0] TEST_OP_IS_WRITE = 6'b01_0100;    // Ops 2 and 4
    localparam mem_word_t TEST_OP_WDATA [2] = '{32'h1122_3344, 32'h9988_7766};

    localparam int STROBE_HOLD_CYCLES = 5;
    localparam int HOLD_CNT_W         = $clog2(STROBE_HOLD_CYCLES);
    localparam port_byte_t IDLE_PATTERN = 8'hff;    // All LEDs on when finished
    localparam int DEFAULT_INIT_WAIT  = 100000;     // About 2ms at 50MHz

endpackage

//--- hw/sdram_tester_top.sv
`timescale 1ns/1ps

module sdram_tester_top #(
    parameter int INIT_WAIT_CYCLES = sdram_tester_pkg::DEFAULT_INIT_WAIT
) (
    input  logic                         sdram_clk,
    input  logic                         rst_n,
    input  logic                         button_b1,
    input  logic                         mem_ready,
    input  sdram_tester_pkg::mem_word_t  mem_rdata,
    output logic                         sdram_reset_n,
    output sdram_tester_pkg::mem_req_t   mem_req,
    output sdram_tester_pkg::port_byte_t port_a
);
    import sdram_tester_pkg::*;

    // Step input
    logic step;

    // Sequencer to access unit
    logic      start;
    logic      op_write;
    mem_addr_t op_addr;
    mem_word_t op_wdata;
    logic      done;

    // Toward the display
    logic       rdata_valid;
    mem_word_t  rdata;
    disp_sel_t  disp_sel;
    logic [1:0] byte_idx;
    op_idx_t    op_idx;

    // ----------------------------------------
    // Instances
    // ----------------------------------------
    button_step u_button_step (
        .sdram_clk (sdram_clk),
        .rst_n     (rst_n),
        .button_b1 (button_b1),
        .step      (step)
    );

    test_sequencer #(
        .INIT_WAIT_CYCLES (INIT_WAIT_CYCLES)
    ) u_test_sequencer (
        .sdram_clk     (sdram_clk),
        .rst_n         (rst_n),
        .step          (step),
        .done          (done),
        .start         (start),
        .op_write      (op_write),
        .op_addr       (op_addr),
        .op_wdata      (op_wdata),
        .sdram_reset_n (sdram_reset_n),
        .disp_sel      (disp_sel),
        .byte_idx      (byte_idx),
        .op_idx        (op_idx)
    );

    mem_access u_mem_access (
        .sdram_clk   (sdram_clk),
        .rst_n       (rst_n),
        .start       (start),
        .op_write    (op_write),
        .op_addr     (op_addr),
        .op_wdata    (op_wdata),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .mem_req     (mem_req),       // Controller forms valid itself
        .done        (done),
        .rdata_valid (rdata_valid),
        .rdata       (rdata)
    );

    port_display u_port_display (
        .sdram_clk   (sdram_clk),
        .rst_n       (rst_n),
        .rdata_valid (rdata_valid),
        .rdata       (rdata),
        .disp_sel    (disp_sel),
        .byte_idx    (byte_idx),
        .op_idx      (op_idx),
        .port_a      (port_a)
    );

endmodule

//--- hw/test_sequencer.sv
`timescale 1ns/1ps

module test_sequencer #(
    parameter int INIT_WAIT_CYCLES = sdram_tester_pkg::DEFAULT_INIT_WAIT
) (
    input  logic                        sdram_clk,
    input  logic                        rst_n,
    input  logic                        step,
    input  logic                        done,
    output logic                        start,
    output logic                        op_write,
    output sdram_tester_pkg::mem_addr_t op_addr,
    output sdram_tester_pkg::mem_word_t op_wdata,
    output logic                        sdram_reset_n,
    output sdram_tester_pkg::disp_sel_t disp_sel,
    output logic [1:0]                  byte_idx,
    output sdram_tester_pkg::op_idx_t   op_idx
);
    import sdram_tester_pkg::*;

    seq_state_t                                state;
    logic [$clog2(INIT_WAIT_CYCLES + 1) - 1:0] init_cnt;   // Settling time

    // Current operation straight from the script tables
    assign op_addr  = TEST_OP_ADDR[op_idx];
    assign op_write = TEST_OP_IS_WRITE[op_idx];
    assign op_wdata = TEST_OP_WDATA[op_idx[2]];     // Op 2 takes word 0 and op 4 word 1

    // Controller held in reset for the first two states
    assign sdram_reset_n = !(state == SEQ_RESET || state == SEQ_RESETTING);

    always_comb begin
        case (state)
            SEQ_SHOW_BYTE: disp_sel = DISP_BYTE;
            SEQ_SHOW_MARK: disp_sel = DISP_MARK;
            SEQ_IDLE:      disp_sel = DISP_IDLE;
            default:       disp_sel = DISP_CLEAR;   // Dark until something to show
        endcase
    end

    // ----------------------------------------
    // Sequencer FSM
    // ----------------------------------------
    always_ff @(posedge sdram_clk) begin
        start <= 1'b0;      // Pulse on entry to SEQ_ACCESS only
        if (!rst_n) begin
            state    <= SEQ_RESET;
            init_cnt <= '0;
            op_idx   <= '0;
            byte_idx <= '0;
        end else begin
            case (state)
                SEQ_RESET: begin
                    init_cnt <= '0;
                    state    <= SEQ_RESETTING;
                end
                SEQ_RESETTING: state <= SEQ_INIT_WAIT;
                SEQ_INIT_WAIT: begin
                    if (int'(init_cnt) == INIT_WAIT_CYCLES) begin
                        op_idx <= '0;
                        start  <= 1'b1;
                        state  <= SEQ_ACCESS;
                    end else begin
                        init_cnt <= init_cnt + 1'b1;
                    end
                end
                SEQ_ACCESS: begin
                    if (done) begin
                        if (op_write) begin
                            state <= SEQ_SHOW_MARK;     // Nothing to show for a write
                        end else begin
                            byte_idx <= 2'd3;           // MSB first
                            state    <= SEQ_SHOW_BYTE;
                        end
                    end
                end
                SEQ_SHOW_BYTE: begin
                    if (step) begin
                        if (byte_idx == 2'd0) begin
                            state <= SEQ_SHOW_MARK;
                        end else begin
                            byte_idx <= byte_idx - 1'b1;
                        end
                    end
                end
                SEQ_SHOW_MARK: begin
                    if (step) begin
                        if (op_idx == op_idx_t'(TEST_OP_COUNT - 1)) begin
                            state <= SEQ_IDLE;      // Script finished
                        end else begin
                            op_idx <= op_idx + 1'b1;
                            start  <= 1'b1;
                            state  <= SEQ_ACCESS;
                        end
                    end
                end
                SEQ_IDLE: state <= SEQ_IDLE;        // Parked for good
                default:  state <= SEQ_RESET;
            endcase
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_start_in_access: assert property (@(posedge sdram_clk) disable iff (!rst_n)
        start |-> state == SEQ_ACCESS);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the SDRAM tester testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_sdram_tester \
    --Mdir obj_dir -o tb_sdram_tester
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sdram_tester > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- sim/sdram_ctrl_model.sv
`timescale 1ns/1ps

module sdram_ctrl_model (
    input  logic                        sdram_clk,
    input  logic                        sdram_reset_n,
    input  sdram_tester_pkg::mem_req_t  mem_req,
    output logic                        mem_ready,     // One cycle pulse per request
    output sdram_tester_pkg::mem_word_t mem_rdata
);
    import sdram_tester_pkg::*;

    localparam int MEM_WORDS = 16;      // Covers every script address

    mem_word_t   mem [MEM_WORDS];
    logic        valid;                 // Request seen by the controller
    logic        valid_q;
    logic        busy;                  // Response still pending
    int unsigned wait_cnt;              // Cycles left until ready
    logic [3:0]  word_idx;              // Word of the open request

    // The controller forms valid itself
    assign valid = mem_req.rstrb | (|mem_req.wmask);

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h5a00_0000 | 32'(i * 4);    // Fill tied to the byte address
        end
        mem_ready = 1'b0;
        mem_rdata = '0;
        valid_q   = 1'b0;
        busy      = 1'b0;
        wait_cnt  = 0;
        word_idx  = '0;
    end

    // ----------------------------------------
    // Request handling on the falling edge
    // ----------------------------------------
    always @(negedge sdram_clk) begin
        mem_ready = 1'b0;
        if (!sdram_reset_n) begin
            valid_q = 1'b0;             // Controller held in reset
            busy    = 1'b0;
        end else begin
            if (valid && !valid_q) begin
                word_idx = mem_req.addr[5:2];
                for (int b = 0; b < 4; b++) begin
                    if (mem_req.wmask[b]) begin
                        mem[word_idx][b*8 +: 8] = mem_req.wdata[b*8 +: 8];  // Byte lane write
                    end
                end
            end
            if (!valid && valid_q) begin
                wait_cnt = $urandom_range(8, 1);    // Random ready latency
                busy     = 1'b1;
            end else if (busy) begin
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    mem_ready = 1'b1;
                    mem_rdata = mem[word_idx];      // Word valid with ready
                    busy      = 1'b0;
                end
            end
            valid_q = valid;
        end
    end

endmodule

//--- sim/tb_sdram_tester.sv
`timescale 1ns/1ps

module tb_sdram_tester;
    import sdram_tester_pkg::*;

    localparam int INIT_WAIT_CYCLES = 200;
    localparam int CLK_PERIOD       = 10;
    localparam int SEED             = 15563;
    localparam int OP_COUNT         = 6;
    localparam int STROBE_CYCLES    = 5;
    localparam int PRESS_MAX        = 20 + 80;      // Longest low plus longest high
    localparam int PRESS_COUNT      = 26;
    localparam int WATCHDOG_CYCLES  = INIT_WAIT_CYCLES + PRESS_COUNT * PRESS_MAX + 1000;
    localparam int SETTLE_CYCLES    = 5;            // Ready to port_a takes three clocks

    // Expected script
    localparam logic [24:0] OP_ADDR [OP_COUNT] = '{
        25'h0, 25'h4, 25'h8, 25'h8, 25'hc, 25'hc
    };
    localparam logic OP_WRITE [OP_COUNT] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
    localparam logic [31:0] OP_WDATA [OP_COUNT] = '{
        32'h0, 32'h0, 32'h1122_3344, 32'h0, 32'h9988_7766, 32'h0
    };

    logic        sdram_clk = 1'b0;
    logic        rst_n;
    logic        button_b1;
    logic        mem_ready;
    mem_word_t   mem_rdata;
    logic        sdram_reset_n;
    mem_req_t    mem_req;
    port_byte_t  port_a;

    logic        rd_on;
    logic        wr_on;
    logic        strobe_q  = 1'b0;
    int unsigned rel_cyc   = 0;     // Cycles since reset release
    int unsigned ready_cnt = 0;     // Responses from the controller
    int unsigned req_idx   = 0;     // Requests completed so far
    int unsigned hold_len  = 0;     // Length of the current strobe
    logic [31:0] exp_mem [4];       // Reference memory by word

    assign rd_on = mem_req.rstrb;
    assign wr_on = |mem_req.wmask;

    sdram_tester_top #(
        .INIT_WAIT_CYCLES (INIT_WAIT_CYCLES)
    ) DUT (
        .sdram_clk     (sdram_clk),
        .rst_n         (rst_n),
        .button_b1     (button_b1),
        .mem_ready     (mem_ready),
        .mem_rdata     (mem_rdata),
        .sdram_reset_n (sdram_reset_n),
        .mem_req       (mem_req),
        .port_a        (port_a)
    );

    sdram_ctrl_model ctrl (
        .sdram_clk     (sdram_clk),
        .sdram_reset_n (sdram_reset_n),
        .mem_req       (mem_req),
        .mem_ready     (mem_ready),
        .mem_rdata     (mem_rdata)
    );

    always #(CLK_PERIOD / 2) sdram_clk = ~sdram_clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            stop_on_error($sformatf("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h",
                                    $time, name, exp, got));
        end
    endtask

    // One press, random hold and release times
    task automatic press_button();
        int unsigned low_len;
        int unsigned high_len;
        low_len   = $urandom_range(20, 4);
        high_len  = $urandom_range(80, 30);
        button_b1 = 1'b0;
        repeat (low_len) @(negedge sdram_clk);
        button_b1 = 1'b1;
        repeat (high_len) @(negedge sdram_clk);
    endtask

    task automatic wait_response(input int unsigned count);
        while (ready_cnt < count) begin
            @(negedge sdram_clk);
        end
        repeat (SETTLE_CYCLES) @(negedge sdram_clk);    // Let the display catch up
    endtask

    // ----------------------------------------
    // Monitors
    // ----------------------------------------
    always @(posedge sdram_clk) begin
        if (rst_n) begin
            rel_cyc = rel_cyc + 1;
            if (mem_ready) begin
                ready_cnt = ready_cnt + 1;
            end
        end
    end

    always @(negedge sdram_clk) begin
        check_equal("sdram_reset_n", sdram_reset_n, (rel_cyc >= 2) ? 32'd1 : 32'd0);
        if (rel_cyc <= INIT_WAIT_CYCLES) begin
            check_equal("port_a", port_a, 32'd0);       // Dark during the init wait
        end
        assert (!(rd_on && wr_on)) else stop_on_error("Read and write strobes active together");
        if (rel_cyc < INIT_WAIT_CYCLES) begin
            assert (!(rd_on || wr_on)) else stop_on_error("Request issued during the init wait");
        end
        if ((rd_on || wr_on) && !strobe_q) begin
            assert (req_idx < OP_COUNT) else stop_on_error("More requests than script operations");
            if (req_idx < OP_COUNT) begin
                check_equal("mem_req.addr", mem_req.addr, OP_ADDR[req_idx]);
                check_equal("write flag", wr_on, OP_WRITE[req_idx]);
                if (wr_on) begin
                    check_equal("mem_req.wmask", mem_req.wmask, 32'hf);
                    check_equal("mem_req.wdata", mem_req.wdata, OP_WDATA[req_idx]);
                end
            end
            hold_len = 1;
        end else if (rd_on || wr_on) begin
            hold_len = hold_len + 1;
        end else if (strobe_q) begin
            check_equal("strobe length", hold_len, STROBE_CYCLES);
            req_idx = req_idx + 1;
        end
        strobe_q = rd_on || wr_on;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_on_error("Timeout: the script did not finish in time");
    end

    // ----------------------------------------
    // Stimulus and expected display
    // ----------------------------------------
    initial begin
        logic [1:0] idx;
        void'($urandom(SEED));
        rst_n     = 1'b0;
        button_b1 = 1'b1;       // Released
        @(negedge sdram_clk);
        exp_mem[0]  = $urandom();   // Words read before any write
        exp_mem[1]  = $urandom();
        exp_mem[2]  = '0;
        exp_mem[3]  = '0;
        ctrl.mem[0] = exp_mem[0];
        ctrl.mem[1] = exp_mem[1];
        repeat (4) @(negedge sdram_clk);
        rst_n = 1'b1;

        for (int op = 0; op < OP_COUNT; op++) begin
            idx = OP_ADDR[op][3:2];
            wait_response(op + 1);
            if (OP_WRITE[op]) begin
                exp_mem[idx] = OP_WDATA[op];
            end else begin
                for (int b = 3; b >= 0; b--) begin
                    check_equal("port_a", port_a, exp_mem[idx][b*8 +: 8]);  // MSB first
                    press_button();
                end
            end
            check_equal("port_a", port_a, op + 1);      // Marker
            press_button();
        end

        // Parked on all ones
        repeat (50) begin
            check_equal("port_a", port_a, 32'hff);
            @(negedge sdram_clk);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
